// File: src.f
+incdir+src
src/dcache_miss_pkg.sv
src/miss_ifs.sv
src/miss_alloc.sv
src/miss_queue.sv
src/line_fetch.sv
src/load_wakeup.sv
src/dcache_miss.sv
sim/axi_read_model.sv
sim/tb_dcache_miss.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f src.f --top-module tb_dcache_miss \
        -Mdir obj_dir -o tb_dcache_miss; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_dcache_miss)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

// File: sim/tb_dcache_miss.sv
`timescale 1ns/10ps
`include "dcache_miss_cfg.svh"

module tb_dcache_miss;
    localparam int CYCLES = 3000;
    localparam int DRAIN_LIMIT = 2000;
    localparam int LQ_SLOTS = 1 << `LQ_IDX_BITS;
    localparam int POOL = 6;

    logic clk;
    logic rst;
    logic ren;
    logic [`PADDR_BITS-1:0] raddr;
    logic [`LQ_IDX_BITS-1:0] lq_idx;
    logic rfull;
    logic wen;
    logic [`PADDR_BITS-1:0] waddr;
    logic [`LINE_BITS-1:0] wdata;
    logic [`LINE_BYTES-1:0] wmask;
    logic wfull;
    logic refill_en;
    logic [`PADDR_BITS-1:0] refill_addr;
    logic [`LINE_BITS-1:0] refill_data;
    logic refill_dirty;
    logic refill_valid;
    logic lq_en;
    logic [`LQ_IDX_BITS-1:0] lq_idx_o;
    logic [`WORD_BITS-1:0] lq_data;
    logic ar_valid;
    logic [`PADDR_BITS-1:0] ar_addr;
    logic ar_ready;
    logic r_valid;
    logic [`WORD_BITS-1:0] r_data;
    logic r_last;

    integer seed;
    int checks;
    int mismatches;
    int other_errors;
    logic fire_pend;
    logic hold_prev;
    logic [`PADDR_BITS-1:0] hold_addr;

    // lines in flight, oldest first
    dcache_miss_pkg::line_addr_t m_line[$];
    logic [`LINE_BITS-1:0] m_data[$];
    logic [`LINE_BYTES-1:0] m_mask[$];

    // accepted loads by load-queue index
    logic ld_busy [LQ_SLOTS];
    logic ld_ready [LQ_SLOTS];
    dcache_miss_pkg::line_addr_t ld_line [LQ_SLOTS];
    logic [`OFFSET_BITS-1:0] ld_off [LQ_SLOTS];
    logic [`WORD_BITS-1:0] ld_word [LQ_SLOTS];

    dcache_miss dcache_miss_i (.*);

    axi_read_model mem_i (
        .clk(clk), .rst(rst),
        .ar_valid(ar_valid), .ar_addr(ar_addr), .ar_ready(ar_ready),
        .r_valid(r_valid), .r_data(r_data), .r_last(r_last)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // memory contents, a mix of line address and word index
    function automatic logic [`WORD_BITS-1:0] mem_word(dcache_miss_pkg::line_addr_t line, int k);
        logic [31:0] x;
        x = 32'(line) * 32'h9e3779b1;
        x = x ^ (32'h7f4a7c15 + 32'(k) * 32'h85ebca6b);
        return x ^ {13'h0, x[31:13]};
    endfunction

    function automatic logic [`LINE_BITS-1:0] mem_line(dcache_miss_pkg::line_addr_t line);
        logic [`LINE_BITS-1:0] d;
        for (int k = 0; k < `LINE_WORDS; k++) begin
            d[k*`WORD_BITS +: `WORD_BITS] = mem_word(line, k);
        end
        return d;
    endfunction

    function automatic dcache_miss_pkg::line_addr_t pool_line(int i);
        return dcache_miss_pkg::line_addr_t'(28'h0040100 + 28'(i) * 28'h13);
    endfunction

    function automatic int find_line(dcache_miss_pkg::line_addr_t line);
        int idx;
        idx = -1;
        for (int i = 0; i < m_line.size(); i++) begin
            if (m_line[i] == line) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic bit any_busy();
        bit b;
        b = 1'b0;
        for (int i = 0; i < LQ_SLOTS; i++) begin
            b = b | ld_busy[i];
        end
        return b;
    endfunction

    task automatic check_val(input string name, input logic [`LINE_BITS-1:0] actual,
                             input logic [`LINE_BITS-1:0] expected);
        checks++;
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch at %0t: %s actual %0h expected %0h", $time, name, actual, expected);
        end
    endtask

    task automatic report_error(input string what);
        other_errors++;
        $display("error at %0t: %s", $time, what);
    endtask

    task automatic add_line(input dcache_miss_pkg::line_addr_t line);
        if (m_line.size() >= `MISS_ENTRIES) begin
            report_error("more lines in flight than queue entries");
        end
        m_line.push_back(line);
        m_data.push_back(mem_line(line));
        m_mask.push_back('0);
    endtask

    // requests sampled at the last rising edge, judged by the full flags
    task automatic accept_requests();
        dcache_miss_pkg::line_addr_t wl;
        dcache_miss_pkg::line_addr_t rl;
        logic [`LINE_BITS-1:0] d;
        int wi;
        wl = waddr[`PADDR_BITS-1:`LINE_OFF_BITS];
        rl = raddr[`PADDR_BITS-1:`LINE_OFF_BITS];
        wi = find_line(wl);
        if (wen && wfull && wi < 0 && m_line.size() < `MISS_ENTRIES) begin
            report_error("store to a new line refused with a free entry");
        end
        // only the head line can already hold its fetched data
        if (wen && wfull && wi > 0) begin
            report_error("store to a line waiting behind the head refused");
        end
        if (wen && !wfull) begin
            if (wi < 0) begin
                add_line(wl);
                wi = m_line.size() - 1;
            end
            d = m_data[wi];
            for (int b = 0; b < `LINE_BYTES; b++) begin
                if (wmask[b]) begin
                    d[b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            m_data[wi] = d;
            m_mask[wi] = m_mask[wi] | wmask;
        end
        if (ren && !rfull) begin
            if (find_line(rl) < 0) begin
                add_line(rl);
            end
            ld_busy[lq_idx] = 1'b1;
            ld_ready[lq_idx] = 1'b0;
            ld_line[lq_idx] = rl;
            ld_off[lq_idx] = raddr[`LINE_OFF_BITS-1:`LINE_OFF_BITS-`OFFSET_BITS];
        end
    endtask

    task automatic apply_refill();
        logic [`LINE_BITS-1:0] d;
        if (fire_pend) begin
            if (m_line.size() == 0) begin
                report_error("refill accepted with no line in flight");
            end else begin
                d = m_data[0];
                for (int i = 0; i < LQ_SLOTS; i++) begin
                    if (ld_busy[i] && !ld_ready[i] && ld_line[i] == m_line[0]) begin
                        ld_ready[i] = 1'b1;
                        ld_word[i] = d[int'(ld_off[i])*`WORD_BITS +: `WORD_BITS];
                    end
                end
                void'(m_line.pop_front());
                void'(m_data.pop_front());
                void'(m_mask.pop_front());
            end
        end
    endtask

    task automatic check_outputs();
        if (lq_en) begin
            if (!ld_busy[lq_idx_o] || !ld_ready[lq_idx_o]) begin
                report_error($sformatf("load %0d returned without a refill of its line",
                                       lq_idx_o));
            end else begin
                check_val("lq_data", lq_data, ld_word[lq_idx_o]);
                ld_busy[lq_idx_o] = 1'b0;
                ld_ready[lq_idx_o] = 1'b0;
            end
        end
        if (hold_prev && !refill_en) begin
            report_error("refill_en dropped before refill_valid");
        end
        if (hold_prev && refill_en) begin
            check_val("refill_addr held", refill_addr, hold_addr);
        end
        if (refill_en) begin
            if (m_line.size() == 0) begin
                report_error("refill offered with no line in flight");
            end else begin
                check_val("refill_addr", refill_addr, {m_line[0], {`LINE_OFF_BITS{1'b0}}});
                check_val("refill_data", refill_data, m_data[0]);
                check_val("refill_dirty", refill_dirty, |m_mask[0]);
            end
        end
        if (ar_valid && m_line.size() != 0) begin
            check_val("ar_addr", ar_addr, {m_line[0], {`LINE_OFF_BITS{1'b0}}});
        end
    endtask

    task automatic drive_inputs(input bit active);
        logic [31:0] r;
        int cand;
        bit found;
        r = $random(seed);
        refill_valid = r[2:0] < 3'd3;
        fire_pend = refill_en && refill_valid;
        hold_prev = refill_en && !refill_valid;
        hold_addr = refill_addr;

        r = $random(seed);
        found = 1'b0;
        for (int t = 0; t < LQ_SLOTS; t++) begin
            cand = (int'(r[15:12]) + t) % LQ_SLOTS;
            if (!found && !ld_busy[cand]) begin
                lq_idx = cand[`LQ_IDX_BITS-1:0];
                found = 1'b1;
            end
        end
        ren = active && r[0] && found;
        raddr = {pool_line(int'(r[10:8]) % POOL), r[7:4]};

        r = $random(seed);
        wen = active && r[2:0] < 3'd3;
        waddr = {pool_line(int'(r[10:8]) % POOL), r[7:4]};
        wmask = r[31:16];
        wdata = {$random(seed), $random(seed), $random(seed), $random(seed)};
    endtask

    task automatic step(input bit active);
        @(negedge clk);
        accept_requests();
        apply_refill();
        check_outputs();
        drive_inputs(active);
    endtask

    initial begin
        bit drained;
        seed = 26361;
        checks = 0;
        mismatches = 0;
        other_errors = 0;
        fire_pend = 1'b0;
        hold_prev = 1'b0;
        hold_addr = '0;
        for (int i = 0; i < LQ_SLOTS; i++) begin
            ld_busy[i] = 1'b0;
            ld_ready[i] = 1'b0;
        end
        rst = 1'b1;
        ren = 1'b0;
        raddr = '0;
        lq_idx = '0;
        wen = 1'b0;
        waddr = '0;
        wdata = '0;
        wmask = '0;
        refill_valid = 1'b0;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_val("rfull after reset", rfull, 1'b0);
        check_val("wfull after reset", wfull, 1'b0);
        check_val("refill_en after reset", refill_en, 1'b0);
        check_val("ar_valid after reset", ar_valid, 1'b0);
        check_val("lq_en after reset", lq_en, 1'b0);

        for (int c = 0; c < CYCLES; c++) begin
            step(1'b1);
        end

        // no new requests, wait for every line and load to finish
        drained = 1'b0;
        for (int t = 0; t < DRAIN_LIMIT && !drained; t++) begin
            step(1'b0);
            drained = m_line.size() == 0 && !any_busy();
        end
        if (!drained) begin
            report_error("timeout waiting for the miss queue and the loads to drain");
        end

        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches,
                 other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: sim/axi_read_model.sv
`timescale 1ns/10ps
`include "dcache_miss_cfg.svh"

module axi_read_model (
    input  logic clk,
    input  logic rst,
    input  logic ar_valid,
    input  logic [`PADDR_BITS-1:0] ar_addr,
    output logic ar_ready,
    output logic r_valid,
    output logic [`WORD_BITS-1:0] r_data,
    output logic r_last
);
    integer seed;
    logic [`PADDR_BITS-1:0] line_base;
    logic [31:0] r;
    int beat;
    int delay;

    // same mixing rule as the memory contents in the testbench
    function automatic logic [`WORD_BITS-1:0] line_word(
        logic [`PADDR_BITS-`LINE_OFF_BITS-1:0] line, int k);
        logic [31:0] x;
        x = 32'(line) * 32'h9e3779b1;
        x = x ^ (32'h7f4a7c15 + 32'(k) * 32'h85ebca6b);
        return x ^ {13'h0, x[31:13]};
    endfunction

    initial begin
        seed = 26361;
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r_data = '0;
        r_last = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && ar_valid) begin
                r = $random(seed);
                delay = int'(r[1:0]);
                for (int d = 0; d < delay; d++) begin
                    @(negedge clk);
                end
                ar_ready = 1'b1;
                line_base = ar_addr;
                @(negedge clk);
                ar_ready = 1'b0;
                beat = 0;
                // beats with random gaps
                while (beat < `LINE_WORDS) begin
                    r = $random(seed);
                    if (r[1:0] != 2'b00) begin
                        r_valid = 1'b1;
                        r_data = line_word(line_base[`PADDR_BITS-1:`LINE_OFF_BITS], beat);
                        r_last = beat == `LINE_WORDS - 1;
                        beat++;
                    end else begin
                        r_valid = 1'b0;
                        r_last = 1'b0;
                    end
                    @(negedge clk);
                end
                r_valid = 1'b0;
                r_last = 1'b0;
            end
        end
    end

endmodule

// File: src/dcache_miss.sv
`timescale 1ns/10ps
`include "dcache_miss_cfg.svh"

module dcache_miss (
    input  logic clk,
    input  logic rst,
    // load misses
    input  logic ren,
    input  logic [`PADDR_BITS-1:0] raddr,
    input  dcache_miss_pkg::lq_idx_t lq_idx,
    output logic rfull,
    // line stores
    input  logic wen,
    input  logic [`PADDR_BITS-1:0] waddr,
    input  dcache_miss_pkg::line_data_t wdata,
    input  dcache_miss_pkg::line_mask_t wmask,
    output logic wfull,
    // refill to the cache
    output logic refill_en,
    output logic [`PADDR_BITS-1:0] refill_addr,
    output dcache_miss_pkg::line_data_t refill_data,
    output logic refill_dirty,
    input  logic refill_valid,
    // load wake-up
    output logic lq_en,
    output dcache_miss_pkg::lq_idx_t lq_idx_o,
    output dcache_miss_pkg::word_t lq_data,
    // read bus
    output logic ar_valid,
    output logic [`PADDR_BITS-1:0] ar_addr,
    input  logic ar_ready,
    input  logic r_valid,
    input  dcache_miss_pkg::word_t r_data,
    input  logic r_last
);
    logic done_en;
    dcache_miss_pkg::miss_idx_t done_idx;
    dcache_miss_pkg::line_data_t done_data;

    alloc_if aq_if ();
    fill_if fq_if ();
    wake_if wk_if ();

    miss_alloc miss_alloc_i (
        .clk(clk), .rst(rst),
        .ren(ren), .raddr(raddr), .lq_idx(lq_idx),
        .wen(wen), .waddr(waddr), .wdata(wdata), .wmask(wmask),
        .rfull(rfull), .wfull(wfull),
        .aq(aq_if.alloc), .wk(wk_if.alloc)
    );

    miss_queue miss_queue_i (
        .clk(clk), .rst(rst),
        .refill_valid(refill_valid), .refill_en(refill_en), .refill_addr(refill_addr),
        .refill_data(refill_data), .refill_dirty(refill_dirty),
        .done_en(done_en), .done_idx(done_idx), .done_data(done_data),
        .aq(aq_if.queue), .fq(fq_if.queue)
    );

    line_fetch line_fetch_i (
        .clk(clk), .rst(rst),
        .ar_ready(ar_ready), .r_valid(r_valid), .r_data(r_data), .r_last(r_last),
        .ar_valid(ar_valid), .ar_addr(ar_addr),
        .fq(fq_if.fetch)
    );

    load_wakeup load_wakeup_i (
        .clk(clk), .rst(rst),
        .done_en(done_en), .done_idx(done_idx), .done_data(done_data),
        .lq_en(lq_en), .lq_idx_o(lq_idx_o), .lq_data(lq_data),
        .wk(wk_if.wake)
    );

endmodule

// File: src/load_wakeup.sv
`timescale 1ns/10ps
`include "dcache_miss_cfg.svh"

module load_wakeup (
    input  logic clk,
    input  logic rst,
    input  logic done_en,
    input  dcache_miss_pkg::miss_idx_t done_idx,
    input  dcache_miss_pkg::line_data_t done_data,
    output logic lq_en,
    output dcache_miss_pkg::lq_idx_t lq_idx_o,
    output dcache_miss_pkg::word_t lq_data,
    wake_if.wake wk
);
    dcache_miss_pkg::waiter_t slot_q [`WAITERS];
    dcache_miss_pkg::word_t word_q [`WAITERS];
    logic [`WAITERS-1:0] ready_q;
    logic [`WAITERS-1:0] slot_valid;
    logic [`WAITERS-1:0] hit_done;
    logic [`WAITER_IDX_BITS-1:0] free_sel;
    logic [`WAITER_IDX_BITS-1:0] ret_sel;
    logic new_ready;

    // lowest free slot and lowest slot ready to return
    always_comb begin
        free_sel = '0;
        ret_sel = '0;
        for (int i = `WAITERS - 1; i >= 0; i--) begin
            slot_valid[i] = slot_q[i].valid;
            hit_done[i] = done_en && slot_q[i].valid && !ready_q[i] && slot_q[i].idx == done_idx;
            if (!slot_q[i].valid) begin
                free_sel = i[`WAITER_IDX_BITS-1:0];
            end
            if (ready_q[i]) begin
                ret_sel = i[`WAITER_IDX_BITS-1:0];
            end
        end
    end

    // a load joining in the refill cycle is woken with the others
    assign new_ready = done_en && wk.wait_idx == done_idx;

    assign wk.waiters_full = &slot_valid;
    assign lq_en = |ready_q;
    assign lq_idx_o = slot_q[ret_sel].lq;
    assign lq_data = word_q[ret_sel];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `WAITERS; i++) begin
                slot_q[i] <= '0;
            end
            ready_q <= '0;
        end else begin
            if (lq_en) begin
                slot_q[ret_sel].valid <= 1'b0;
            end
            ready_q <= (ready_q | hit_done) & ~(lq_en ? (`WAITERS'(1) << ret_sel) : '0);
            if (wk.wait_en) begin
                slot_q[free_sel] <= '{valid: 1'b1, idx: wk.wait_idx, lq: wk.wait_lq,
                                      offset: wk.wait_offset};
                ready_q[free_sel] <= new_ready;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `WAITERS; i++) begin
            if (hit_done[i]) begin
                word_q[i] <= done_data[slot_q[i].offset];
            end
        end
        if (wk.wait_en) begin
            word_q[free_sel] <= done_data[wk.wait_offset];
        end
    end

endmodule

// File: src/line_fetch.sv
`timescale 1ns/10ps
`include "dcache_miss_cfg.svh"

module line_fetch (
    input  logic clk,
    input  logic rst,
    input  logic ar_ready,
    input  logic r_valid,
    input  dcache_miss_pkg::word_t r_data,
    input  logic r_last,
    output logic ar_valid,
    output logic [`PADDR_BITS-1:0] ar_addr,
    fill_if.fetch fq
);
    dcache_miss_pkg::fill_state_e state;
    dcache_miss_pkg::offset_t beat_cnt;
    dcache_miss_pkg::line_data_t beats_q;
    logic [`PADDR_BITS-1:0] addr_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= dcache_miss_pkg::FILL_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                dcache_miss_pkg::FILL_IDLE: begin
                    if (fq.head_pending) begin
                        state <= dcache_miss_pkg::FILL_ADDR;
                    end
                end
                dcache_miss_pkg::FILL_ADDR: begin
                    if (ar_ready) begin
                        state <= dcache_miss_pkg::FILL_DATA;
                        beat_cnt <= '0;
                    end
                end
                dcache_miss_pkg::FILL_DATA: begin
                    if (r_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (r_last) begin
                            state <= dcache_miss_pkg::FILL_MERGE;
                        end
                    end
                end
                default: state <= dcache_miss_pkg::FILL_IDLE;
            endcase
        end
    end

    // line base held for the whole address phase
    always_ff @(posedge clk) begin
        if (state == dcache_miss_pkg::FILL_IDLE && fq.head_pending) begin
            addr_q <= {fq.head_line, {`LINE_OFF_BITS{1'b0}}};
        end
        if (state == dcache_miss_pkg::FILL_DATA && r_valid) begin
            beats_q[beat_cnt] <= r_data;
        end
    end

    assign ar_valid = state == dcache_miss_pkg::FILL_ADDR;
    assign ar_addr = addr_q;

    // store bytes collected during the burst take priority
    assign fq.fill_done = state == dcache_miss_pkg::FILL_MERGE;
    assign fq.fill_data = dcache_miss_pkg::merge_line(beats_q, fq.head_data, fq.head_mask);

endmodule

// File: src/miss_queue.sv
`timescale 1ns/10ps
`include "dcache_miss_cfg.svh"

module miss_queue (
    input  logic clk,
    input  logic rst,
    input  logic refill_valid,
    output logic refill_en,
    output logic [`PADDR_BITS-1:0] refill_addr,
    output dcache_miss_pkg::line_data_t refill_data,
    output logic refill_dirty,
    output logic done_en,
    output dcache_miss_pkg::miss_idx_t done_idx,
    output dcache_miss_pkg::line_data_t done_data,
    alloc_if.queue aq,
    fill_if.queue fq
);
    localparam logic [`MISS_IDX_BITS:0] DEPTH = `MISS_ENTRIES;

    logic [`MISS_ENTRIES-1:0] valid_q;
    logic [`MISS_ENTRIES-1:0] ready_q;
    dcache_miss_pkg::line_addr_t [`MISS_ENTRIES-1:0] line_q;
    dcache_miss_pkg::line_data_t data_q [`MISS_ENTRIES];
    dcache_miss_pkg::line_mask_t mask_q [`MISS_ENTRIES];
    dcache_miss_pkg::line_data_t data_nxt [`MISS_ENTRIES];
    dcache_miss_pkg::line_mask_t mask_nxt [`MISS_ENTRIES];
    dcache_miss_pkg::miss_idx_t head;
    dcache_miss_pkg::miss_idx_t tail;
    logic [`MISS_IDX_BITS:0] count;

    assign aq.valid = valid_q;
    assign aq.line = line_q;
    assign aq.data_ready = ready_q;
    assign aq.tail = tail;
    assign aq.free_cnt = DEPTH - count;

    assign fq.head_pending = valid_q[head] && !ready_q[head];
    assign fq.head_line = line_q[head];
    assign fq.head_data = data_q[head];
    assign fq.head_mask = mask_q[head];

    assign refill_en = valid_q[head] && ready_q[head];
    assign refill_addr = {line_q[head], {`LINE_OFF_BITS{1'b0}}};
    assign refill_data = data_q[head];
    assign refill_dirty = |mask_q[head];

    assign done_en = refill_en && refill_valid;
    assign done_idx = head;
    assign done_data = data_q[head];

    // a store landing in the fill cycle goes on top of the fetched line
    always_comb begin
        for (int i = 0; i < `MISS_ENTRIES; i++) begin
            data_nxt[i] = data_q[i];
            mask_nxt[i] = mask_q[i];
            if (aq.alloc_en && int'(tail) == i) begin
                mask_nxt[i] = '0;
            end
            if (fq.fill_done && int'(head) == i) begin
                data_nxt[i] = fq.fill_data;
            end
            if (aq.merge_en && int'(aq.merge_idx) == i) begin
                data_nxt[i] = dcache_miss_pkg::merge_line(data_nxt[i], aq.merge_data,
                                                          aq.merge_mask);
                mask_nxt[i] = mask_nxt[i] | aq.merge_mask;
            end
        end
    end

    always_ff @(posedge clk) begin
        data_q <= data_nxt;
        mask_q <= mask_nxt;
        if (aq.alloc_en) begin
            line_q[tail] <= aq.alloc_line;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
            ready_q <= '0;
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (aq.alloc_en) begin
                valid_q[tail] <= 1'b1;
                ready_q[tail] <= 1'b0;
                tail <= tail + 1'b1;
            end
            if (fq.fill_done) begin
                ready_q[head] <= 1'b1;
            end
            if (done_en) begin
                valid_q[head] <= 1'b0;
                ready_q[head] <= 1'b0;
                head <= head + 1'b1;
            end
            case ({aq.alloc_en, done_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: src/miss_alloc.sv
`timescale 1ns/10ps
`include "dcache_miss_cfg.svh"

module miss_alloc (
    input  logic clk,
    input  logic rst,
    input  logic ren,
    input  logic [`PADDR_BITS-1:0] raddr,
    input  dcache_miss_pkg::lq_idx_t lq_idx,
    input  logic wen,
    input  logic [`PADDR_BITS-1:0] waddr,
    input  dcache_miss_pkg::line_data_t wdata,
    input  dcache_miss_pkg::line_mask_t wmask,
    output logic rfull,
    output logic wfull,
    alloc_if.alloc aq,
    wake_if.alloc wk
);
    dcache_miss_pkg::line_addr_t r_line;
    dcache_miss_pkg::line_addr_t w_line;
    logic [`MISS_ENTRIES-1:0] r_hit_vec;
    logic [`MISS_ENTRIES-1:0] w_hit_vec;
    dcache_miss_pkg::miss_idx_t r_hit_idx;
    dcache_miss_pkg::miss_idx_t w_hit_idx;
    logic r_hit;
    logic w_hit;
    logic w_blocked;
    logic rw_same;
    logic space;
    logic w_acc;
    logic w_new;
    logic r_shared;
    logic r_acc;
    logic r_new;

    assign r_line = raddr[`PADDR_BITS-1:`LINE_OFF_BITS];
    assign w_line = waddr[`PADDR_BITS-1:`LINE_OFF_BITS];

    // at most one entry holds a given line
    always_comb begin
        r_hit_idx = '0;
        w_hit_idx = '0;
        for (int i = 0; i < `MISS_ENTRIES; i++) begin
            r_hit_vec[i] = aq.valid[i] && (aq.line[i] == r_line);
            w_hit_vec[i] = aq.valid[i] && (aq.line[i] == w_line);
            if (r_hit_vec[i]) begin
                r_hit_idx = dcache_miss_pkg::miss_idx_t'(i);
            end
            if (w_hit_vec[i]) begin
                w_hit_idx = dcache_miss_pkg::miss_idx_t'(i);
            end
        end
    end

    assign r_hit = |r_hit_vec;
    assign w_hit = |w_hit_vec;
    // line already fetched, store bytes would be lost
    assign w_blocked = |(w_hit_vec & aq.data_ready);
    assign rw_same = ren && wen && (r_line == w_line);
    assign space = aq.free_cnt != '0;

    // store wins the single tail slot
    assign w_acc = wen && !w_blocked && (w_hit || space);
    assign w_new = w_acc && !w_hit;
    assign r_shared = rw_same && w_new;
    assign r_acc = ren && !wk.waiters_full && (r_hit || r_shared || (space && !w_new));
    assign r_new = r_acc && !r_hit && !r_shared;

    assign aq.alloc_en = w_new || r_new;
    assign aq.alloc_line = w_new ? w_line : r_line;

    assign aq.merge_en = w_acc;
    assign aq.merge_idx = w_hit ? w_hit_idx : aq.tail;
    assign aq.merge_data = wdata;
    assign aq.merge_mask = wmask;

    assign wk.wait_en = r_acc;
    assign wk.wait_idx = r_hit ? r_hit_idx : aq.tail;
    assign wk.wait_lq = lq_idx;
    assign wk.wait_offset = raddr[`LINE_OFF_BITS-1:`LINE_OFF_BITS-`OFFSET_BITS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rfull <= 1'b0;
            wfull <= 1'b0;
        end else begin
            rfull <= ren && !r_acc;
            wfull <= wen && !w_acc;
        end
    end

endmodule

// File: src/miss_ifs.sv
`timescale 1ns/10ps
`include "dcache_miss_cfg.svh"

interface alloc_if;
    logic [`MISS_ENTRIES-1:0] valid;
    dcache_miss_pkg::line_addr_t [`MISS_ENTRIES-1:0] line;
    logic [`MISS_ENTRIES-1:0] data_ready;
    dcache_miss_pkg::miss_idx_t tail;
    logic [`MISS_IDX_BITS:0] free_cnt;

    logic alloc_en;
    dcache_miss_pkg::line_addr_t alloc_line;
    logic merge_en;
    dcache_miss_pkg::miss_idx_t merge_idx;
    dcache_miss_pkg::line_data_t merge_data;
    dcache_miss_pkg::line_mask_t merge_mask;

    modport alloc (input valid, line, data_ready, tail, free_cnt,
                   output alloc_en, alloc_line, merge_en, merge_idx, merge_data, merge_mask);
    modport queue (output valid, line, data_ready, tail, free_cnt,
                   input alloc_en, alloc_line, merge_en, merge_idx, merge_data, merge_mask);
endinterface

interface fill_if;
    logic head_pending;
    dcache_miss_pkg::line_addr_t head_line;
    dcache_miss_pkg::line_data_t head_data;
    dcache_miss_pkg::line_mask_t head_mask;
    logic fill_done;
    dcache_miss_pkg::line_data_t fill_data;

    modport queue (output head_pending, head_line, head_data, head_mask,
                   input fill_done, fill_data);
    modport fetch (input head_pending, head_line, head_data, head_mask,
                   output fill_done, fill_data);
endinterface

interface wake_if;
    logic wait_en;
    dcache_miss_pkg::miss_idx_t wait_idx;
    dcache_miss_pkg::lq_idx_t wait_lq;
    dcache_miss_pkg::offset_t wait_offset;
    logic waiters_full;

    modport alloc (output wait_en, wait_idx, wait_lq, wait_offset, input waiters_full);
    modport wake (input wait_en, wait_idx, wait_lq, wait_offset, output waiters_full);
endinterface

// File: src/dcache_miss_pkg.sv
`include "dcache_miss_cfg.svh"

package dcache_miss_pkg;

    typedef logic [`PADDR_BITS-`LINE_OFF_BITS-1:0] line_addr_t;
    typedef logic [`WORD_BITS-1:0] word_t;
    typedef word_t [`LINE_WORDS-1:0] line_data_t;
    typedef logic [`LINE_BYTES-1:0] line_mask_t;
    typedef logic [`MISS_IDX_BITS-1:0] miss_idx_t;
    typedef logic [`OFFSET_BITS-1:0] offset_t;
    typedef logic [`LQ_IDX_BITS-1:0] lq_idx_t;

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_ADDR,
        FILL_DATA,
        FILL_MERGE
    } fill_state_e;

    typedef struct packed {
        logic valid;
        miss_idx_t idx;
        lq_idx_t lq;
        offset_t offset;
    } waiter_t;

    // bytes of new_d replace old_d where the mask bit is set
    function automatic line_data_t merge_line(line_data_t old_d, line_data_t new_d,
                                              line_mask_t m);
        logic [`LINE_BITS-1:0] res;
        logic [`LINE_BITS-1:0] src;
        res = old_d;
        src = new_d;
        for (int b = 0; b < `LINE_BYTES; b++) begin
            if (m[b]) begin
                res[b*8 +: 8] = src[b*8 +: 8];
            end
        end
        return res;
    endfunction

endpackage

// File: src/dcache_miss_cfg.svh
`ifndef DCACHE_MISS_CFG_SVH
`define DCACHE_MISS_CFG_SVH

// queue and waiter table sizes
`define MISS_ENTRIES 4
`define WAITERS 4

// address and data widths
`define PADDR_BITS 32
`define WORD_BITS 32
`define LINE_WORDS 4
`define LQ_IDX_BITS 4

// derived sizes
`define MISS_IDX_BITS $clog2(`MISS_ENTRIES)
`define WAITER_IDX_BITS $clog2(`WAITERS)
`define OFFSET_BITS $clog2(`LINE_WORDS)
`define WORD_BYTES (`WORD_BITS / 8)
`define LINE_BYTES (`LINE_WORDS * `WORD_BYTES)
`define LINE_BITS (`LINE_WORDS * `WORD_BITS)
`define LINE_OFF_BITS $clog2(`LINE_BYTES)

`endif
